// File: source/imem_pkg.sv
/*
  Instruction memory access package
  Word and region sizing, privilege and fetch state encodings,
  the region entry layout, bus protection bits and the checker verdict
*/

package imem_pkg;

  ////////////////////
  // Sizing
  ////////////////////

  // Address and data word width
  localparam int XLEN      = 32;

  // Region table depth and index width
  localparam int PMA_CNT   = 4;
  localparam int PMA_IDX_W = $clog2(PMA_CNT);

  // Regions are whole 4 KiB pages
  localparam int PAGE_LSB  = 12;
  localparam int PPN_W     = XLEN - PAGE_LSB;

  ////////////////////
  // Encodings
  ////////////////////

  // Privilege levels, RISC-V encoding
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_M = 2'b11
  } prv_e;

  // Fetch core states
  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    BUS_REQ,
    BUS_WAIT,
    DRAIN
  } fetch_state_e;

  // One region, base and limit both inclusive
  typedef struct packed {
    logic             valid;
    logic             exec;
    logic             user;
    logic [PPN_W-1:0] base_pn;
    logic [PPN_W-1:0] limit_pn;
  } pma_entry_t;

  // Bus protection attributes
  typedef struct packed {
    logic instruction;
    logic privileged;
  } biu_prot_t;

  // Checker verdict for the registered fetch
  typedef struct packed {
    logic misaligned;
    logic pma_err;
    logic allowed;
  } chk_result_t;

endpackage

// File: source/imem_pma_regs.sv
/*
  Region table register block
  Holds PMA_CNT region entries for the fetch checker
  One entry is written per configuration strobe
  Reset clears every valid bit
*/

`timescale 1ns/1ps

module imem_pma_regs
  import imem_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // Configuration write port
  input  logic                 cfg_we_i,
  input  logic [PMA_IDX_W-1:0] cfg_idx_i,
  input  pma_entry_t           cfg_entry_i,

  // Table to the checker
  output pma_entry_t           pma_table_o [PMA_CNT]
);

  pma_entry_t           table_q [PMA_CNT];
  // Entries written since reset
  logic [PMA_CNT-1:0]   written_q;

  ////////////////////
  // Table storage
  ////////////////////

  // Only valid bits are cleared, the rest is don't care until written
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < PMA_CNT; i++)
      begin
        table_q[i].valid <= 1'b0;
      end
      written_q <= '0;
    end
    else if (cfg_we_i)
    begin
      table_q[cfg_idx_i]   <= cfg_entry_i;
      written_q[cfg_idx_i] <= 1'b1;
    end
  end

  assign pma_table_o = table_q;

  // An entry nobody wrote must never look valid to the checker
  for (genvar g = 0; g < PMA_CNT; g++)
  begin : g_valid_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
      !written_q[g] |-> !table_q[g].valid);
  end

endmodule

// File: source/imem_access_chk.sv
/*
  Fetch access checker
  Flags misaligned fetch addresses and searches the region table
  for the lowest matching valid entry, then applies exec and
  user permission to decide if the fetch may go to the bus
  Combinational, clk_i only samples the assertion
*/

`timescale 1ns/1ps

module imem_access_chk
  import imem_pkg::*;
(
  input  logic            clk_i,

  // Registered fetch from the core
  input  logic [XLEN-1:0] fetch_adr_i,
  input  prv_e            fetch_prv_i,

  // Region table
  input  pma_entry_t      pma_table_i [PMA_CNT],

  // Verdict
  output chk_result_t     chk_o
);

  logic [PPN_W-1:0]   fetch_pn;
  logic [PMA_CNT-1:0] match;
  logic               hit;
  pma_entry_t         sel;
  logic               misaligned;
  logic               region_err;

  // Page number of the fetch
  assign fetch_pn = fetch_adr_i[XLEN-1:PAGE_LSB];

  ////////////////////
  // Region search
  ////////////////////

  // Per entry window compare
  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      match[i] = pma_table_i[i].valid &&
                 (pma_table_i[i].base_pn  <= fetch_pn) &&
                 (pma_table_i[i].limit_pn >= fetch_pn);
    end
  end

  // Lowest index wins, so walk downwards and let the last hit stick
  always_comb
  begin
    hit = 1'b0;
    sel = '0;
    for (int i = PMA_CNT-1; i >= 0; i--)
    begin
      if (match[i])
      begin
        hit = 1'b1;
        sel = pma_table_i[i];
      end
    end
  end

  ////////////////////
  // Verdict
  ////////////////////

  // No compressed parcels, both low bits must be zero
  assign misaligned = |fetch_adr_i[1:0];

  // No region, no exec, or user mode without user permission
  assign region_err = !hit || !sel.exec || ((fetch_prv_i == PRV_U) && !sel.user);

  // Misalignment masks the region error
  assign chk_o.misaligned = misaligned;
  assign chk_o.pma_err    = !misaligned && region_err;
  assign chk_o.allowed    = !misaligned && !region_err;

  // Allowed fetch is aligned and inside the chosen executable window
  assert property (@(posedge clk_i)
    chk_o.allowed |-> (fetch_adr_i[1:0] == 2'b00) && sel.valid && sel.exec &&
                      ((fetch_prv_i == PRV_M) || sel.user) &&
                      (sel.base_pn <= fetch_pn) && (sel.limit_pn >= fetch_pn));

endmodule

// File: source/imem_fetch_core.sv
/*
  Fetch core
  Latches one CPU fetch, waits for the checker verdict, then either
  answers at once or runs a word read on the BIU
  A flush drops the fetch, an open bus transfer is drained first
*/

`timescale 1ns/1ps

module imem_fetch_core
  import imem_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,

  // CPU request side
  input  logic            imem_req_i,
  input  logic            imem_flush_i,
  input  logic [XLEN-1:0] imem_adr_i,
  input  prv_e            st_prv_i,

  // Checker
  output logic [XLEN-1:0] fetch_adr_o,
  output prv_e            fetch_prv_o,
  input  chk_result_t     chk_i,

  // CPU answer
  output logic            imem_ack_o,
  output logic [XLEN-1:0] parcel_o,
  output logic            err_o,
  output logic            misaligned_o,

  // BIU
  output logic            biu_stb_o,
  input  logic            biu_stb_ack_i,
  output logic [XLEN-1:0] biu_adri_o,
  output biu_prot_t       biu_prot_o,
  input  logic [XLEN-1:0] biu_q_i,
  input  logic            biu_ack_i,
  input  logic            biu_err_i
);

  fetch_state_e    state_q, state_d;
  // Strobe still open while draining
  logic            drain_stb_q, drain_stb_d;
  logic            ack_q, ack_d;
  logic [XLEN-1:0] parcel_q, parcel_d;
  logic            err_q, err_d;
  logic            misal_q, misal_d;
  logic [XLEN-1:0] fetch_adr_q;
  prv_e            fetch_prv_q;
  logic            bus_done;

  assign bus_done = biu_ack_i || biu_err_i;

  ////////////////////
  // Next state
  ////////////////////

  always_comb
  begin
    state_d     = state_q;
    drain_stb_d = drain_stb_q;
    ack_d       = 1'b0;
    parcel_d    = '0;
    err_d       = 1'b0;
    misal_d     = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (imem_req_i) state_d = CHECK;
      end
      CHECK:
      begin
        // Refused fetch answers straight away, never touches the bus
        if (imem_flush_i) state_d = IDLE;
        else if (chk_i.allowed) state_d = BUS_REQ;
        else
        begin
          ack_d   = 1'b1;
          err_d   = chk_i.pma_err;
          misal_d = chk_i.misaligned;
          state_d = IDLE;
        end
      end
      BUS_REQ:
      begin
        if (imem_flush_i)
        begin
          state_d     = DRAIN;
          drain_stb_d = !biu_stb_ack_i;
        end
        else if (biu_stb_ack_i) state_d = BUS_WAIT;
      end
      BUS_WAIT:
      begin
        if (bus_done)
        begin
          state_d = IDLE;
          // Flush in the same cycle still swallows the answer
          if (!imem_flush_i)
          begin
            ack_d    = 1'b1;
            err_d    = biu_err_i;
            parcel_d = biu_err_i ? '0 : biu_q_i;
          end
        end
        else if (imem_flush_i)
        begin
          state_d     = DRAIN;
          drain_stb_d = 1'b0;
        end
      end
      DRAIN:
      begin
        // Finish the strobe first, then drop the answer
        if (drain_stb_q)
        begin
          if (biu_stb_ack_i) drain_stb_d = 1'b0;
        end
        else if (bus_done) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q     <= IDLE;
      drain_stb_q <= 1'b0;
      ack_q       <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      drain_stb_q <= drain_stb_d;
      ack_q       <= ack_d;
    end
  end

  // Request latch and answer payload
  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && imem_req_i)
    begin
      fetch_adr_q <= imem_adr_i;
      fetch_prv_q <= st_prv_i;
    end
    if (ack_d)
    begin
      parcel_q <= parcel_d;
      err_q    <= err_d;
      misal_q  <= misal_d;
    end
  end

  assign fetch_adr_o  = fetch_adr_q;
  assign fetch_prv_o  = fetch_prv_q;

  assign imem_ack_o   = ack_q;
  assign parcel_o     = parcel_q;
  assign err_o        = err_q;
  assign misaligned_o = misal_q;

  // Strobe stays up in DRAIN until the BIU takes it
  assign biu_stb_o               = (state_q == BUS_REQ) || (state_q == DRAIN && drain_stb_q);
  assign biu_adri_o              = fetch_adr_q;
  assign biu_prot_o.instruction  = 1'b1;
  assign biu_prot_o.privileged   = (fetch_prv_q == PRV_M);

  ////////////////////
  // Assertions
  ////////////////////

  assert property (@(posedge clk_i) disable iff (reset_i)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adri_o));

  assert property (@(posedge clk_i) disable iff (reset_i)
    imem_ack_o |=> !imem_ack_o);

  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == DRAIN) |-> !imem_ack_o);

endmodule

// File: source/imem_ctrl.sv
/*
  Instruction memory access block, no cache
  Region table, fetch checker and fetch core between the CPU
  fetch port and the BIU
*/

`timescale 1ns/1ps

module imem_ctrl
  import imem_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // Configuration
  input  logic                 cfg_we_i,
  input  logic [PMA_IDX_W-1:0] cfg_idx_i,
  input  pma_entry_t           cfg_entry_i,

  // CPU side
  input  logic                 imem_req_i,
  input  logic                 imem_flush_i,
  input  logic [XLEN-1:0]      imem_adr_i,
  input  prv_e                 st_prv_i,
  output logic                 imem_ack_o,
  output logic [XLEN-1:0]      parcel_o,
  output logic                 err_o,
  output logic                 misaligned_o,

  // BIU
  output logic                 biu_stb_o,
  input  logic                 biu_stb_ack_i,
  output logic [XLEN-1:0]      biu_adri_o,
  output biu_prot_t            biu_prot_o,
  input  logic [XLEN-1:0]      biu_q_i,
  input  logic                 biu_ack_i,
  input  logic                 biu_err_i
);

  pma_entry_t      pma_table [PMA_CNT];
  logic [XLEN-1:0] fetch_adr;
  prv_e            fetch_prv;
  chk_result_t     chk;

  // Region table
  imem_pma_regs pma_regs_inst (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_idx_i   ( cfg_idx_i   ),
    .cfg_entry_i ( cfg_entry_i ),
    .pma_table_o ( pma_table   )
  );

  // Misalignment and region check on the latched fetch
  imem_access_chk access_chk_inst (
    .clk_i       ( clk_i     ),
    .fetch_adr_i ( fetch_adr ),
    .fetch_prv_i ( fetch_prv ),
    .pma_table_i ( pma_table ),
    .chk_o       ( chk       )
  );

  // Fetch FSM and BIU handshake
  imem_fetch_core fetch_core_inst (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .imem_req_i    ( imem_req_i    ),
    .imem_flush_i  ( imem_flush_i  ),
    .imem_adr_i    ( imem_adr_i    ),
    .st_prv_i      ( st_prv_i      ),
    .fetch_adr_o   ( fetch_adr     ),
    .fetch_prv_o   ( fetch_prv     ),
    .chk_i         ( chk           ),
    .imem_ack_o    ( imem_ack_o    ),
    .parcel_o      ( parcel_o      ),
    .err_o         ( err_o         ),
    .misaligned_o  ( misaligned_o  ),
    .biu_stb_o     ( biu_stb_o     ),
    .biu_stb_ack_i ( biu_stb_ack_i ),
    .biu_adri_o    ( biu_adri_o    ),
    .biu_prot_o    ( biu_prot_o    ),
    .biu_q_i       ( biu_q_i       ),
    .biu_ack_i     ( biu_ack_i     ),
    .biu_err_i     ( biu_err_i     )
  );

endmodule

// File: verification/imem_ctrl_model.svh
/*
  Reference model for the instruction memory access block
  Region lookup on the testbench copy of the table, the BIU
  data pattern and the expected CPU answer for one fetch
*/

`ifndef IMEM_CTRL_MODEL_SVH
`define IMEM_CTRL_MODEL_SVH

// Expected or observed CPU answer
typedef struct packed {
  logic            to_bus;
  logic            err;
  logic            misaligned;
  logic [XLEN-1:0] parcel;
} answer_t;

// Responder data is the address with these bits flipped
localparam logic [XLEN-1:0] BUS_PATTERN = 32'h5A3C_96E1;

function automatic logic [XLEN-1:0] bus_word(input logic [XLEN-1:0] adr);
  return adr ^ BUS_PATTERN;
endfunction

// Bit 20 set means the bus answers with an error
function automatic logic bus_fails(input logic [XLEN-1:0] adr);
  return adr[20];
endfunction

// First valid entry holding the page decides, none means refused
function automatic logic region_ok(input logic [XLEN-1:0] adr, input prv_e prv);
  logic [PPN_W-1:0] pn;
  pn = adr[XLEN-1:PAGE_LSB];
  for (int i = 0; i < PMA_CNT; i++)
  begin
    if (model_table[i].valid && pn >= model_table[i].base_pn &&
        pn <= model_table[i].limit_pn)
    begin
      return model_table[i].exec && (prv == PRV_M || model_table[i].user);
    end
  end
  return 1'b0;
endfunction

// Misalignment first, then region, then the bus outcome
function automatic answer_t expect_answer(input logic [XLEN-1:0] adr, input prv_e prv);
  answer_t a;
  a = '0;
  if (adr[1:0] != 2'b00) a.misaligned = 1'b1;
  else if (!region_ok(adr, prv)) a.err = 1'b1;
  else
  begin
    a.to_bus = 1'b1;
    if (bus_fails(adr)) a.err = 1'b1;
    else a.parcel = bus_word(adr);
  end
  return a;
endfunction

`endif

// File: verification/imem_ctrl_tb.sv
/*
  Testbench for the instruction memory access block
  Random region tables and fetches checked against a reference model,
  a BIU responder with random delays, flush and refused fetch timing
*/

`timescale 1ns/1ps

module imem_ctrl_tb
  import imem_pkg::*;
();

  localparam int SEED     = 65638;
  localparam int N_EMPTY  = 20;
  localparam int N_RANDOM = 150;
  localparam int N_MISAL  = 40;
  localparam int N_PRIV   = 20;
  localparam int N_FLUSH  = 30;
  localparam int N_TIMING = 20;
  // Privilege and flush tests issue two fetches per round
  localparam int N_FETCH  = N_EMPTY + N_RANDOM + N_MISAL + 2*N_PRIV + 2*N_FLUSH + N_TIMING;
  // Slowest fetch about 10 edges, plus config writes and reset
  localparam int TIMEOUT  = N_FETCH * 12 + 200;

  logic                 clk_i;
  logic                 reset_i;
  logic                 cfg_we_i;
  logic [PMA_IDX_W-1:0] cfg_idx_i;
  pma_entry_t           cfg_entry_i;
  logic                 imem_req_i;
  logic                 imem_flush_i;
  logic [XLEN-1:0]      imem_adr_i;
  prv_e                 st_prv_i;
  logic                 imem_ack_o;
  logic [XLEN-1:0]      parcel_o;
  logic                 err_o;
  logic                 misaligned_o;
  logic                 biu_stb_o;
  logic                 biu_stb_ack_i;
  logic [XLEN-1:0]      biu_adri_o;
  biu_prot_t            biu_prot_o;
  logic [XLEN-1:0]      biu_q_i;
  logic                 biu_ack_i;
  logic                 biu_err_i;

  // Testbench copy of the region table
  pma_entry_t           model_table [PMA_CNT];
  // Responder bookkeeping
  int                   stb_count;
  logic                 bus_busy;
  logic [XLEN-1:0]      bus_adr;
  biu_prot_t            bus_prot;
  int                   cycles;
  int                   errors;
  int                   checks;
  int                   test_errors;
  int                   test_checks;
  int                   tests;

  `include "imem_ctrl_model.svh"

  imem_ctrl imem_ctrl_inst (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Ends a run that stops making progress
  initial
  begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", TIMEOUT);
    $display("Errors found");
    $finish;
  end

  ////////////////////
  // BIU responder
  ////////////////////

  initial
  begin : biu_responder
    int stb_delay;
    int ans_delay;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    stb_count     = 0;
    bus_busy      = 1'b0;
    bus_adr       = '0;
    bus_prot      = '0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (biu_stb_o)
      begin
        stb_count++;
        bus_busy  = 1'b1;
        bus_adr   = biu_adri_o;
        bus_prot  = biu_prot_o;
        stb_delay = $urandom_range(0, 3);
        ans_delay = $urandom_range(1, 4);
        repeat (stb_delay)
        begin
          @(posedge clk_i);
          #1;
        end
        biu_stb_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        biu_stb_ack_i = 1'b0;
        repeat (ans_delay - 1)
        begin
          @(posedge clk_i);
          #1;
        end
        // Answer for one edge
        if (bus_fails(bus_adr)) biu_err_i = 1'b1;
        else
        begin
          biu_ack_i = 1'b1;
          biu_q_i   = bus_word(bus_adr);
        end
        @(posedge clk_i);
        #1;
        biu_ack_i = 1'b0;
        biu_err_i = 1'b0;
        biu_q_i   = '0;
        bus_busy  = 1'b0;
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    checks++;
    test_checks++;
    if (expected !== actual)
    begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-10s %0d checks, %0d mismatches", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic write_entry(input int idx, input pma_entry_t e);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = PMA_IDX_W'(idx);
    cfg_entry_i = e;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
    model_table[idx] = e;
  endtask

  // Mostly valid and executable, windows up to 256 pages
  function automatic pma_entry_t random_entry();
    pma_entry_t e;
    e.valid    = ($urandom_range(0, 3) != 0);
    e.exec     = ($urandom_range(0, 3) != 0);
    e.user     = ($urandom_range(0, 1) == 1);
    e.base_pn  = PPN_W'($urandom_range(0, 'h3FF));
    e.limit_pn = e.base_pn + PPN_W'($urandom_range(0, 'hFF));
    return e;
  endfunction

  function automatic pma_entry_t fixed_entry(input int base, input int limit, input logic user);
    pma_entry_t e;
    e.valid    = 1'b1;
    e.exec     = 1'b1;
    e.user     = user;
    e.base_pn  = PPN_W'(base);
    e.limit_pn = PPN_W'(limit);
    return e;
  endfunction

  function automatic prv_e random_prv();
    if ($urandom_range(0, 1) == 1) return PRV_M;
    return PRV_U;
  endfunction

  // Pages 0 to 0x3FF, so bit 20 is random
  function automatic logic [XLEN-1:0] random_adr(input logic misaligned);
    logic [XLEN-1:0] r;
    r = $urandom();
    r[XLEN-1:22] = '0;
    r[1:0] = misaligned ? 2'($urandom_range(1, 3)) : 2'b00;
    return r;
  endfunction

  // Aligned address inside a page range
  function automatic logic [XLEN-1:0] region_adr(input int lo_pn, input int hi_pn);
    logic [XLEN-1:0] adr;
    adr = $urandom();
    adr[XLEN-1:PAGE_LSB] = PPN_W'($urandom_range(lo_pn, hi_pn));
    adr[1:0] = 2'b00;
    return adr;
  endfunction

  // One request strobe, then wait for the ack
  task automatic fetch(input logic [XLEN-1:0] adr, input prv_e prv,
                       output answer_t got, output int lat);
    int start;
    start      = stb_count;
    imem_adr_i = adr;
    st_prv_i   = prv;
    imem_req_i = 1'b1;
    @(posedge clk_i);
    #1;
    imem_req_i = 1'b0;
    lat = 1;
    while (!imem_ack_o)
    begin
      @(posedge clk_i);
      #1;
      lat++;
    end
    got.to_bus     = (stb_count != start);
    got.err        = err_o;
    got.misaligned = misaligned_o;
    got.parcel     = parcel_o;
  endtask

  task automatic run_check(input string name, input logic [XLEN-1:0] adr, input prv_e prv);
    answer_t   exp;
    answer_t   got;
    biu_prot_t exp_prot;
    int        lat;
    exp = expect_answer(adr, prv);
    exp_prot.instruction = 1'b1;
    exp_prot.privileged  = (prv == PRV_M);
    fetch(adr, prv, got, lat);
    compare({name, " to_bus"}, 64'(exp.to_bus), 64'(got.to_bus));
    compare({name, " err"}, 64'(exp.err), 64'(got.err));
    compare({name, " misaligned"}, 64'(exp.misaligned), 64'(got.misaligned));
    compare({name, " parcel"}, 64'(exp.parcel), 64'(got.parcel));
    if (exp.to_bus)
    begin
      compare({name, " bus adr"}, 64'(adr), 64'(bus_adr));
      compare({name, " prot"}, 64'(exp_prot), 64'(bus_prot));
    end
    else
    begin
      // Refused fetch answers two edges after the request
      compare({name, " latency"}, 64'(2), 64'(lat));
    end
  endtask

  // Flush after 0 to 2 edges, while the fetch is surely still open
  task automatic flushed_fetch(input logic [XLEN-1:0] adr, input int flush_at);
    int n;
    imem_adr_i = adr;
    st_prv_i   = PRV_M;
    imem_req_i = 1'b1;
    @(posedge clk_i);
    #1;
    imem_req_i = 1'b0;
    repeat (flush_at)
    begin
      @(posedge clk_i);
      #1;
      compare("flush ack", 64'(0), 64'(imem_ack_o));
    end
    imem_flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    imem_flush_i = 1'b0;
    // Stay until the drained transfer is over
    n = 0;
    while (n < 3 || bus_busy)
    begin
      compare("flush ack", 64'(0), 64'(imem_ack_o));
      @(posedge clk_i);
      #1;
      n++;
    end
    compare("flush ack", 64'(0), 64'(imem_ack_o));
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial
  begin : main
    logic [XLEN-1:0] adr;
    void'($urandom(SEED));
    reset_i      = 1'b1;
    cfg_we_i     = 1'b0;
    cfg_idx_i    = '0;
    cfg_entry_i  = '0;
    imem_req_i   = 1'b0;
    imem_flush_i = 1'b0;
    imem_adr_i   = '0;
    st_prv_i     = PRV_M;
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    test_checks  = 0;
    tests        = 0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      model_table[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    compare("reset ack", 64'(0), 64'(imem_ack_o));
    compare("reset stb", 64'(0), 64'(biu_stb_o));
    end_test("reset");

    // Empty table refuses everything
    for (int i = 0; i < N_EMPTY; i++) run_check("empty", random_adr(1'b0), random_prv());
    end_test("empty");

    // New random table every 30 fetches
    for (int i = 0; i < N_RANDOM; i++)
    begin
      if (i % 30 == 0)
      begin
        for (int k = 0; k < PMA_CNT; k++) write_entry(k, random_entry());
      end
      run_check("random", random_adr(1'b0), random_prv());
    end
    end_test("random");

    for (int i = 0; i < N_MISAL; i++) run_check("misalign", random_adr(1'b1), random_prv());
    end_test("misalign");

    // Machine only window, then a user window
    write_entry(0, fixed_entry('h40, 'h7F, 1'b0));
    write_entry(1, fixed_entry('h80, 'hBF, 1'b1));
    write_entry(2, '0);
    write_entry(3, '0);
    for (int i = 0; i < N_PRIV; i++)
    begin
      adr = region_adr('h40, 'hBF);
      run_check("priv", adr, PRV_U);
      run_check("priv", adr, PRV_M);
    end
    end_test("priv");

    for (int i = 0; i < N_FLUSH; i++)
    begin
      flushed_fetch(region_adr('h40, 'hBF), $urandom_range(0, 2));
      run_check("flush", region_adr('h40, 'hBF), random_prv());
    end
    end_test("flush");

    // Pages outside both windows
    for (int i = 0; i < N_TIMING; i++) run_check("timing", region_adr('h100, 'h3FF), random_prv());
    end_test("timing");

    $display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
    if (errors == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: imem_ctrl.f
+incdir+verification
source/imem_pkg.sv
source/imem_pma_regs.sv
source/imem_access_chk.sv
source/imem_fetch_core.sv
source/imem_ctrl.sv
verification/imem_ctrl_tb.sv

// File: Makefile
# Verilator build for the instruction memory access block

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = imem_ctrl_tb
FILELIST = imem_ctrl.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
